// ==== common/bev_pkg.sv ====
package bev_pkg;

    // ==============================
    // widths and volumes
    // ==============================
    localparam int ING_W       = 12;
    localparam int DAY_FIELD_W = 8;
    localparam int BOX_W       = 8;
    localparam int CMD_W       = 9;
    // recipe amounts never exceed a large cup
    localparam int REC_W       = 10;

    localparam logic [REC_W-1:0] ML_L = 10'd960;
    localparam logic [REC_W-1:0] ML_M = 10'd720;
    localparam logic [REC_W-1:0] ML_S = 10'd480;

    // ==============================
    // enums
    // ==============================
    // supply is still decoded so it can be rejected
    typedef enum logic [1:0] {
        make_drink,
        supply,
        check_date
    } action_e;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } bev_type_e;

    typedef enum logic [1:0] {
        l,
        m,
        s
    } bev_size_e;

    // ing_of kept for code compatibility only
    typedef enum logic [1:0] {
        no_err,
        no_exp,
        no_ing,
        ing_of
    } err_e;

    // ==============================
    // command bus views
    // ==============================
    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    typedef struct packed {
        logic [CMD_W-3:0] pad;
        action_e          value;
    } cmd_act_t;

    typedef struct packed {
        logic [CMD_W-4:0] pad;
        bev_type_e        value;
    } cmd_type_t;

    typedef struct packed {
        logic [CMD_W-3:0] pad;
        bev_size_e        value;
    } cmd_size_t;

    typedef struct packed {
        logic [CMD_W-BOX_W-1:0] pad;
        logic [BOX_W-1:0]       box_no;
    } cmd_box_t;

    // one bus word, meaning picked by the active strobe
    typedef union packed {
        cmd_act_t  act;
        cmd_type_t bev;
        cmd_size_t size;
        date_t     date;
        cmd_box_t  box;
    } cmd_data_u;

    // ==============================
    // records
    // ==============================
    // memory word layout, msb first
    typedef struct packed {
        logic [ING_W-1:0]       black_tea;
        logic [ING_W-1:0]       green_tea;
        logic [DAY_FIELD_W-1:0] month;
        logic [ING_W-1:0]       milk;
        logic [ING_W-1:0]       pineapple_juice;
        logic [DAY_FIELD_W-1:0] day;
    } barrel_t;

    typedef struct packed {
        logic [REC_W-1:0] black_tea;
        logic [REC_W-1:0] green_tea;
        logic [REC_W-1:0] milk;
        logic [REC_W-1:0] pineapple_juice;
    } recipe_t;

    typedef struct packed {
        action_e          act;
        bev_type_e        bev;
        bev_size_e        size;
        date_t            today;
        logic [BOX_W-1:0] box_no;
    } order_t;

    // amounts per drink, split as halves and quarters of the cup
    function automatic recipe_t recipe(input bev_type_e bev, input bev_size_e size);
        logic [REC_W-1:0] full;
        logic [REC_W-1:0] half;
        logic [REC_W-1:0] quarter;
        recipe_t          r;
        case (size)
            l:       full = ML_L;
            m:       full = ML_M;
            s:       full = ML_S;
            default: full = '0;
        endcase
        half    = full >> 1;
        quarter = full >> 2;
        r       = '0;
        case (bev)
            black_tea:       r.black_tea = full;
            milk_tea: begin
                r.black_tea = full - quarter;
                r.milk      = quarter;
            end
            extra_milk_tea: begin
                r.black_tea = half;
                r.milk      = half;
            end
            green_tea:       r.green_tea = full;
            green_milk_tea: begin
                r.green_tea = half;
                r.milk      = half;
            end
            pineapple_juice: r.pineapple_juice = full;
            super_pineapple_tea: begin
                r.black_tea       = half;
                r.pineapple_juice = half;
            end
            default: begin
                // super pineapple milk tea
                r.black_tea       = half;
                r.milk            = quarter;
                r.pineapple_juice = quarter;
            end
        endcase
        return r;
    endfunction

endpackage

// ==== hdl/bev_order_capture.sv ====
`timescale 1ns/1ps

module bev_order_capture (
    input  logic                clk,
    input  logic                inf,
    input  logic                sel_action_valid,
    input  logic                type_valid,
    input  logic                size_valid,
    input  logic                date_valid,
    input  logic                box_no_valid,
    input  bev_pkg::cmd_data_u  d,
    input  logic                out_valid,
    output bev_pkg::order_t     order,
    output logic                order_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_make,
        st_check,
        st_wait
    } state_e;

    state_e state;
    state_e state_n;
    logic   box_take;

    // box number closes the command in either action
    assign box_take = box_no_valid && (state == st_make || state == st_check);

    // ==============================
    // action fsm
    // ==============================
    always_comb begin
        state_n = state;
        case (state)
            st_idle: begin
                if (sel_action_valid) begin
                    case (d.act.value)
                        bev_pkg::make_drink: state_n = st_make;
                        bev_pkg::check_date: state_n = st_check;
                        // supply dropped, no order issued
                        bev_pkg::supply:     state_n = st_idle;
                        default:             state_n = st_idle;
                    endcase
                end
            end
            st_make, st_check: begin
                if (box_take) begin
                    state_n = st_wait;
                end
            end
            default: begin
                if (out_valid) begin
                    state_n = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state       <= st_idle;
            order_valid <= 1'b0;
        end else begin
            state       <= state_n;
            order_valid <= box_take;
        end
    end

    // field latches, one view of d per strobe
    always_ff @(posedge clk) begin
        if (state == st_idle && sel_action_valid) begin
            order.act <= d.act.value;
        end
        if (state == st_make && type_valid) begin
            order.bev <= d.bev.value;
        end
        if (state == st_make && size_valid) begin
            order.size <= d.size.value;
        end
        if ((state == st_make || state == st_check) && date_valid) begin
            order.today <= d.date;
        end
        if (box_take) begin
            order.box_no <= d.box.box_no;
        end
    end

endmodule

// ==== barrel/barrel_bridge.sv ====
`timescale 1ns/1ps

module barrel_bridge (
    input  logic                          clk,
    input  logic                          inf,
    input  bev_pkg::order_t               order,
    input  logic                          order_valid,
    input  logic                          wr_req,
    input  bev_pkg::barrel_t              wr_data,
    input  logic                          c_out_valid,
    input  bev_pkg::barrel_t              c_data_r,
    output logic                          c_in_valid,
    output logic [bev_pkg::BOX_W-1:0]     c_addr,
    output logic                          c_r_wb,
    output bev_pkg::barrel_t              c_data_w,
    output bev_pkg::barrel_t              barrel,
    output logic                          rd_done,
    output logic                          wr_done
);

    // ==============================
    // request side
    // ==============================
    // c_r_wb holds until the answer, so it also marks what is outstanding
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            c_in_valid <= 1'b0;
            c_r_wb     <= 1'b1;
        end else begin
            c_in_valid <= order_valid || wr_req;
            if (order_valid) begin
                c_r_wb <= 1'b1;
            end else if (wr_req) begin
                c_r_wb <= 1'b0;
            end
        end
    end

    // address taken from the order, reused by the write back
    always_ff @(posedge clk) begin
        if (order_valid) begin
            c_addr <= order.box_no;
        end
        if (wr_req) begin
            c_data_w <= wr_data;
        end
    end

    // ==============================
    // answer side
    // ==============================
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            rd_done <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            rd_done <= c_out_valid && c_r_wb;
            wr_done <= c_out_valid && !c_r_wb;
        end
    end

    // keep the read word stable for the judge
    always_ff @(posedge clk) begin
        if (c_out_valid && c_r_wb) begin
            barrel <= c_data_r;
        end
    end

endmodule

// ==== hdl/bev_judge.sv ====
`timescale 1ns/1ps

module bev_judge (
    input  logic               clk,
    input  logic               inf,
    input  bev_pkg::order_t    order,
    input  logic               rd_done,
    input  bev_pkg::barrel_t   barrel,
    input  logic               wr_done,
    output logic               wr_req,
    output bev_pkg::barrel_t   wr_data,
    output logic               out_valid,
    output bev_pkg::err_e      err_msg,
    output logic               complete
);

    bev_pkg::recipe_t                  rec;
    logic [bev_pkg::DAY_FIELD_W-1:0]   today_m;
    logic [bev_pkg::DAY_FIELD_W-1:0]   today_d;
    logic [bev_pkg::ING_W:0]           bt_left;
    logic [bev_pkg::ING_W:0]           gt_left;
    logic [bev_pkg::ING_W:0]           mk_left;
    logic [bev_pkg::ING_W:0]           pj_left;
    logic                              expired;
    logic                              short_ing;
    bev_pkg::err_e                     err_c;
    bev_pkg::err_e                     v_err;
    bev_pkg::action_e                  v_act;
    logic                              judged;
    logic                              need_wr;

    // ==============================
    // decision
    // ==============================
    assign rec     = bev_pkg::recipe(order.bev, order.size);
    assign today_m = bev_pkg::DAY_FIELD_W'(order.today.month);
    assign today_d = bev_pkg::DAY_FIELD_W'(order.today.day);

    assign expired = (today_m > barrel.month) ||
                     (today_m == barrel.month && today_d > barrel.day);

    // top bit is the borrow
    assign bt_left = {1'b0, barrel.black_tea} - (bev_pkg::ING_W + 1)'(rec.black_tea);
    assign gt_left = {1'b0, barrel.green_tea} - (bev_pkg::ING_W + 1)'(rec.green_tea);
    assign mk_left = {1'b0, barrel.milk} - (bev_pkg::ING_W + 1)'(rec.milk);
    assign pj_left = {1'b0, barrel.pineapple_juice}
                   - (bev_pkg::ING_W + 1)'(rec.pineapple_juice);

    assign short_ing = bt_left[bev_pkg::ING_W] | gt_left[bev_pkg::ING_W] |
                       mk_left[bev_pkg::ING_W] | pj_left[bev_pkg::ING_W];

    // expiry wins over shortage
    always_comb begin
        if (expired) begin
            err_c = bev_pkg::no_exp;
        end else if (order.act == bev_pkg::make_drink && short_ing) begin
            err_c = bev_pkg::no_ing;
        end else begin
            err_c = bev_pkg::no_err;
        end
    end

    // ==============================
    // verdict and response
    // ==============================
    assign need_wr = (v_act == bev_pkg::make_drink) && (v_err == bev_pkg::no_err);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            judged    <= 1'b0;
            wr_req    <= 1'b0;
            out_valid <= 1'b0;
            v_err     <= bev_pkg::no_err;
            v_act     <= bev_pkg::make_drink;
        end else begin
            judged    <= rd_done;
            wr_req    <= rd_done && order.act == bev_pkg::make_drink &&
                         err_c == bev_pkg::no_err;
            // no write: right after the verdict, else after the write lands
            out_valid <= (judged && !need_wr) || wr_done;
            if (rd_done) begin
                v_err <= err_c;
                v_act <= order.act;
            end
        end
    end

    // reduced contents, dates kept
    always_ff @(posedge clk) begin
        if (rd_done) begin
            wr_data.black_tea       <= bt_left[bev_pkg::ING_W-1:0];
            wr_data.green_tea       <= gt_left[bev_pkg::ING_W-1:0];
            wr_data.month           <= barrel.month;
            wr_data.milk            <= mk_left[bev_pkg::ING_W-1:0];
            wr_data.pineapple_juice <= pj_left[bev_pkg::ING_W-1:0];
            wr_data.day             <= barrel.day;
        end
    end

    assign err_msg  = out_valid ? v_err : bev_pkg::no_err;
    assign complete = out_valid && (v_err == bev_pkg::no_err);

endmodule

// ==== hdl/bev_top.sv ====
`timescale 1ns/1ps

module bev_top (
    input  logic                       clk,
    input  logic                       inf,
    input  logic                       sel_action_valid,
    input  logic                       type_valid,
    input  logic                       size_valid,
    input  logic                       date_valid,
    input  logic                       box_no_valid,
    input  bev_pkg::cmd_data_u         d,
    input  logic                       c_out_valid,
    input  bev_pkg::barrel_t           c_data_r,
    output logic                       c_in_valid,
    output logic [bev_pkg::BOX_W-1:0]  c_addr,
    output logic                       c_r_wb,
    output bev_pkg::barrel_t           c_data_w,
    output logic                       out_valid,
    output bev_pkg::err_e              err_msg,
    output logic                       complete
);

    bev_pkg::order_t  order;
    logic             order_valid;
    bev_pkg::barrel_t barrel;
    logic             rd_done;
    logic             wr_done;
    logic             wr_req;
    bev_pkg::barrel_t wr_data;

    // ==============================
    // stages
    // ==============================
    bev_order_capture u_capture (
        .clk              (clk),
        .inf              (inf),
        .sel_action_valid (sel_action_valid),
        .type_valid       (type_valid),
        .size_valid       (size_valid),
        .date_valid       (date_valid),
        .box_no_valid     (box_no_valid),
        .d                (d),
        .out_valid        (out_valid),
        .order            (order),
        .order_valid      (order_valid)
    );

    barrel_bridge u_bridge (
        .clk         (clk),
        .inf         (inf),
        .order       (order),
        .order_valid (order_valid),
        .wr_req      (wr_req),
        .wr_data     (wr_data),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .c_in_valid  (c_in_valid),
        .c_addr      (c_addr),
        .c_r_wb      (c_r_wb),
        .c_data_w    (c_data_w),
        .barrel      (barrel),
        .rd_done     (rd_done),
        .wr_done     (wr_done)
    );

    bev_judge u_judge (
        .clk       (clk),
        .inf       (inf),
        .order     (order),
        .rd_done   (rd_done),
        .barrel    (barrel),
        .wr_done   (wr_done),
        .wr_req    (wr_req),
        .wr_data   (wr_data),
        .out_valid (out_valid),
        .err_msg   (err_msg),
        .complete  (complete)
    );

endmodule

// ==== dv/bev_checker.sv ====
`timescale 1ns/1ps

module bev_checker (
    input  logic                       clk,
    input  logic                       inf,
    input  logic                       sel_action_valid,
    input  logic                       type_valid,
    input  logic                       size_valid,
    input  logic                       date_valid,
    input  logic                       box_no_valid,
    input  bev_pkg::cmd_data_u         d,
    input  logic                       c_in_valid,
    input  logic [bev_pkg::BOX_W-1:0]  c_addr,
    input  logic                       c_r_wb,
    input  bev_pkg::barrel_t           c_data_w,
    input  logic                       out_valid,
    input  bev_pkg::err_e              err_msg,
    input  logic                       complete,
    input  bev_pkg::barrel_t           init_image [256],
    output int                         value_errs,
    output int                         proto_errs,
    output int                         responses
);

    typedef struct packed {
        bev_pkg::err_e    err;
        logic             done;
        bev_pkg::barrel_t nxt;
    } verdict_t;

    bev_pkg::barrel_t    shadow [256];
    bev_pkg::action_e    cur_act;
    bev_pkg::bev_type_e  cur_bev;
    bev_pkg::bev_size_e  cur_size;
    bev_pkg::date_t      cur_today;
    verdict_t            v;
    bev_pkg::err_e       exp_err;
    logic                exp_done;
    logic                exp_wr;
    int                  exp_box;
    int                  n_reads;
    int                  n_writes;
    logic                pending;

    // expected verdict from the recipe table and the date rule
    function automatic verdict_t predict(input bev_pkg::action_e act,
                                         input bev_pkg::bev_type_e bev,
                                         input bev_pkg::bev_size_e size,
                                         input bev_pkg::date_t today,
                                         input bev_pkg::barrel_t b);
        bev_pkg::recipe_t r;
        verdict_t         res;
        logic             late;
        logic             lacking;
        r        = bev_pkg::recipe(bev, size);
        res.nxt  = b;
        res.done = 1'b0;
        late     = (int'(today.month) > int'(b.month)) ||
                   (int'(today.month) == int'(b.month) && int'(today.day) > int'(b.day));
        lacking  = (int'(b.black_tea) < int'(r.black_tea)) ||
                   (int'(b.green_tea) < int'(r.green_tea)) ||
                   (int'(b.milk) < int'(r.milk)) ||
                   (int'(b.pineapple_juice) < int'(r.pineapple_juice));
        if (late) begin
            res.err = bev_pkg::no_exp;
        end else if (act == bev_pkg::make_drink && lacking) begin
            res.err = bev_pkg::no_ing;
        end else begin
            res.err  = bev_pkg::no_err;
            res.done = 1'b1;
            if (act == bev_pkg::make_drink) begin
                res.nxt.black_tea       = b.black_tea - 12'(r.black_tea);
                res.nxt.green_tea       = b.green_tea - 12'(r.green_tea);
                res.nxt.milk            = b.milk - 12'(r.milk);
                res.nxt.pineapple_juice = b.pineapple_juice - 12'(r.pineapple_juice);
            end
        end
        return res;
    endfunction

    // ==============================
    // command capture and compare
    // ==============================
    always @(posedge clk) begin
        if (!inf) begin
            for (int a = 0; a < 256; a++) begin
                shadow[a] = init_image[a];
            end
            pending    = 1'b0;
            exp_wr     = 1'b0;
            n_reads    = 0;
            n_writes   = 0;
            value_errs = 0;
            proto_errs = 0;
            responses  = 0;
        end else begin
            if (sel_action_valid) cur_act = d.act.value;
            if (type_valid) cur_bev = d.bev.value;
            if (size_valid) cur_size = d.size.value;
            if (date_valid) cur_today = d.date;
            if (box_no_valid) begin
                exp_box  = int'(d.box.box_no);
                v        = predict(cur_act, cur_bev, cur_size, cur_today, shadow[exp_box]);
                exp_err  = v.err;
                exp_done = v.done;
                exp_wr   = (cur_act == bev_pkg::make_drink && v.err == bev_pkg::no_err);
                // only a successful make drink changes the barrel
                if (exp_wr) begin
                    shadow[exp_box] = v.nxt;
                end
                n_reads  = 0;
                n_writes = 0;
                pending  = 1'b1;
            end
            // bridge requests, one read and at most one write per command
            if (c_in_valid) begin
                if (!pending) begin
                    $display("bridge request at %0t with no command outstanding", $time);
                    proto_errs++;
                end else if (c_addr != bev_pkg::BOX_W'(exp_box)) begin
                    $display("[ERROR] %0t: bridge address %0d, expected box %0d",
                             $time, c_addr, exp_box);
                    value_errs++;
                end
                if (c_r_wb) begin
                    n_reads++;
                end else begin
                    n_writes++;
                    if (!exp_wr) begin
                        $display("[ERROR] %0t: write to box %0d that must stay unchanged",
                                 $time, exp_box);
                        value_errs++;
                    end else if (c_data_w != shadow[exp_box]) begin
                        $display("[ERROR] %0t: box %0d written %h, expected %h",
                                 $time, exp_box, c_data_w, shadow[exp_box]);
                        value_errs++;
                    end
                end
            end
            if (out_valid) begin
                if (!pending) begin
                    $display("out_valid at %0t with no command outstanding", $time);
                    proto_errs++;
                end else begin
                    if (err_msg != exp_err || complete != exp_done) begin
                        $display("[ERROR] %0t: box %0d err_msg %s complete %0b, expected %s %0b",
                                 $time, exp_box, err_msg.name(), complete, exp_err.name(),
                                 exp_done);
                        value_errs++;
                    end
                    if (n_reads != 1 || n_writes != int'(exp_wr)) begin
                        $display("[ERROR] %0t: box %0d saw %0d reads and %0d writes",
                                 $time, exp_box, n_reads, n_writes);
                        value_errs++;
                    end
                end
                pending = 1'b0;
                responses++;
            end else if (err_msg != bev_pkg::no_err || complete) begin
                $display("[ERROR] %0t: err_msg or complete active without out_valid", $time);
                value_errs++;
            end
        end
    end

endmodule

// ==== dv/bev_tb.sv ====
`timescale 1ns/1ps

module bev_tb;

    localparam int N_RAND     = 200;
    localparam int N_DIRECTED = 11;
    // strobe gaps, read and write latency, slack
    localparam int CMD_CYCLES = 5 * 3 + 2 * 8 + 10;
    localparam int WATCHDOG   = 10 + (N_RAND + N_DIRECTED) * CMD_CYCLES;

    logic                      clk;
    logic                      inf;
    logic                      sel_action_valid;
    logic                      type_valid;
    logic                      size_valid;
    logic                      date_valid;
    logic                      box_no_valid;
    bev_pkg::cmd_data_u        d;
    logic                      c_out_valid;
    bev_pkg::barrel_t          c_data_r;
    logic                      c_in_valid;
    logic [bev_pkg::BOX_W-1:0] c_addr;
    logic                      c_r_wb;
    bev_pkg::barrel_t          c_data_w;
    logic                      out_valid;
    bev_pkg::err_e             err_msg;
    logic                      complete;
    bev_pkg::barrel_t          mem [256];
    bev_pkg::barrel_t          init_image [256];
    int                        value_errs;
    int                        proto_errs;
    int                        responses;
    int                        n_sent;

    bev_top bev_top_i (
        .clk(clk), .inf(inf),
        .sel_action_valid(sel_action_valid), .type_valid(type_valid),
        .size_valid(size_valid), .date_valid(date_valid), .box_no_valid(box_no_valid),
        .d(d), .c_out_valid(c_out_valid), .c_data_r(c_data_r),
        .c_in_valid(c_in_valid), .c_addr(c_addr), .c_r_wb(c_r_wb), .c_data_w(c_data_w),
        .out_valid(out_valid), .err_msg(err_msg), .complete(complete)
    );

    bev_checker bev_checker_i (
        .clk(clk), .inf(inf),
        .sel_action_valid(sel_action_valid), .type_valid(type_valid),
        .size_valid(size_valid), .date_valid(date_valid), .box_no_valid(box_no_valid),
        .d(d), .c_in_valid(c_in_valid), .c_addr(c_addr), .c_r_wb(c_r_wb),
        .c_data_w(c_data_w), .out_valid(out_valid), .err_msg(err_msg), .complete(complete),
        .init_image(init_image), .value_errs(value_errs), .proto_errs(proto_errs),
        .responses(responses)
    );

    // boxes 1 to 3 are set up for the directed cases
    function automatic bev_pkg::barrel_t gen_barrel(input int addr);
        bev_pkg::barrel_t b;
        b.black_tea       = 12'((addr * 97 + 1500) % 4096);
        b.green_tea       = 12'((addr * 53 + 2500) % 4096);
        b.month           = 8'(1 + (addr * 5) % 12);
        b.milk            = 12'((addr * 29 + 800) % 4096);
        b.pineapple_juice = 12'((addr * 71 + 3000) % 4096);
        b.day             = 8'(1 + (addr * 11) % 31);
        case (addr)
            1: b = {12'hfff, 12'hfff, 8'd12, 12'hfff, 12'hfff, 8'd31};
            2: b = {12'd2000, 12'd2000, 8'd6, 12'd2000, 12'd2000, 8'd15};
            // milk one short of a large milk tea
            3: b = {12'hfff, 12'd0, 8'd12, 12'd239, 12'd0, 8'd31};
            default: ;
        endcase
        return b;
    endfunction

    function automatic bev_pkg::date_t mk_date(input int month, input int day);
        bev_pkg::date_t t;
        t.month = 4'(month);
        t.day   = 5'(day);
        return t;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // memory model
    // ==============================
    initial begin : memory_model
        int               lat;
        logic [7:0]       addr;
        logic             rd;
        bev_pkg::barrel_t wdat;
        for (int a = 0; a < 256; a++) begin
            mem[a]        = gen_barrel(a);
            init_image[a] = gen_barrel(a);
        end
        c_out_valid <= 1'b0;
        c_data_r    <= '0;
        forever begin
            @(posedge clk);
            c_out_valid <= 1'b0;
            if (c_in_valid) begin
                addr = c_addr;
                rd   = c_r_wb;
                wdat = c_data_w;
                lat  = 1 + int'($urandom % 8);
                repeat (lat - 1) @(posedge clk);
                if (rd) begin
                    c_data_r <= mem[addr];
                end else begin
                    mem[addr] = wdat;
                end
                c_out_valid <= 1'b1;
            end
        end
    end

    // one strobe for a cycle, then a gap of one or two cycles
    task automatic send_field(input int sel, input logic [8:0] word);
        @(posedge clk);
        d <= word;
        case (sel)
            0: sel_action_valid <= 1'b1;
            1: type_valid <= 1'b1;
            2: size_valid <= 1'b1;
            3: date_valid <= 1'b1;
            default: box_no_valid <= 1'b1;
        endcase
        @(posedge clk);
        sel_action_valid <= 1'b0;
        type_valid       <= 1'b0;
        size_valid       <= 1'b0;
        date_valid       <= 1'b0;
        box_no_valid     <= 1'b0;
        d                <= 9'($urandom);
        repeat (int'($urandom % 2)) @(posedge clk);
    endtask

    task automatic wait_response();
        n_sent++;
        @(posedge clk);
        while (!out_valid) @(posedge clk);
    endtask

    task automatic make_drink(input bev_pkg::bev_type_e bev, input bev_pkg::bev_size_e size,
                              input bev_pkg::date_t today, input logic [7:0] box);
        send_field(0, 9'(bev_pkg::make_drink));
        send_field(1, 9'(bev));
        send_field(2, 9'(size));
        send_field(3, 9'(today));
        send_field(4, 9'(box));
        wait_response();
    endtask

    task automatic check_date(input bev_pkg::date_t today, input logic [7:0] box);
        send_field(0, 9'(bev_pkg::check_date));
        send_field(3, 9'(today));
        send_field(4, 9'(box));
        wait_response();
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin : stimulus
        int             failed;
        bev_pkg::date_t t;
        logic [7:0]     box;
        void'($urandom(42409));
        n_sent    = 0;
        inf              <= 1'b0;
        sel_action_valid <= 1'b0;
        type_valid       <= 1'b0;
        size_valid       <= 1'b0;
        date_valid       <= 1'b0;
        box_no_valid     <= 1'b0;
        d                <= '0;
        repeat (10) @(posedge clk);
        inf <= 1'b1;

        // full barrel, then a reread through the shadow memory
        make_drink(bev_pkg::black_tea, bev_pkg::l, mk_date(1, 1), 8'd1);
        check_date(mk_date(1, 1), 8'd1);
        make_drink(bev_pkg::milk_tea, bev_pkg::m, mk_date(3, 3), 8'd1);
        // expiry, equal month with a later day, then the equal date
        make_drink(bev_pkg::green_tea, bev_pkg::s, mk_date(7, 1), 8'd2);
        make_drink(bev_pkg::green_tea, bev_pkg::s, mk_date(6, 16), 8'd2);
        make_drink(bev_pkg::green_tea, bev_pkg::s, mk_date(6, 15), 8'd2);
        // one unit of milk short, twice to see the barrel unchanged
        make_drink(bev_pkg::milk_tea, bev_pkg::l, mk_date(1, 1), 8'd3);
        make_drink(bev_pkg::milk_tea, bev_pkg::l, mk_date(1, 1), 8'd3);
        make_drink(bev_pkg::black_tea, bev_pkg::l, mk_date(1, 1), 8'd3);
        check_date(mk_date(7, 1), 8'd2);
        check_date(mk_date(1, 1), 8'd2);

        for (int i = 0; i < N_RAND; i++) begin
            t   = mk_date(1 + int'($urandom % 12), 1 + int'($urandom % 31));
            // mostly a few boxes so barrels get reused
            box = ($urandom % 4 == 0) ? 8'($urandom) : 8'($urandom % 16);
            if ($urandom % 4 == 0) begin
                check_date(t, box);
            end else begin
                make_drink(bev_pkg::bev_type_e'($urandom % 8),
                           bev_pkg::bev_size_e'($urandom % 3), t, box);
            end
        end

        repeat (3) @(posedge clk);
        failed = value_errs + proto_errs;
        if (responses != n_sent) begin
            $display("got %0d responses for %0d commands", responses, n_sent);
            failed++;
        end
        $display("errors: %0d wrong values, %0d protocol, %0d of %0d responses",
                 value_errs, proto_errs, responses, n_sent);
        if (failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: out_valid did not arrive within %0d cycles", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== bev.f ====
common/bev_pkg.sv
hdl/bev_order_capture.sv
barrel/barrel_bridge.sv
hdl/bev_judge.sv
hdl/bev_top.sv
dv/bev_checker.sv
dv/bev_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f bev.f --top-module bev_tb -o bev_sim
./obj_dir/bev_sim > sim.log 2>&1
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
